// File: snake_top.f
snake_pkg.sv
snake_body.sv
cell_lookup.sv
frame_tracker.sv
snake_top.sv
tb_snake_top.sv

// File: Makefile
SRCS := $(shell cat snake_top.f)

.PHONY: all run clean

all: obj_dir/Vtb_snake_top

obj_dir/Vtb_snake_top: $(SRCS) snake_top.f
	verilator --binary --timing --assert --top-module tb_snake_top \
		-Mdir obj_dir -f snake_top.f

run: obj_dir/Vtb_snake_top
	./obj_dir/Vtb_snake_top | tee sim.log
	grep -q "^ALL CHECKS PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_snake_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snake_top
    import snake_pkg::*;
;

    localparam int max_len   = 16;
    localparam int n_tiles   = grid_w * grid_h;
    localparam int n_scans   = 12;
    localparam int max_gap   = 3;
    localparam int cycle_cap = n_scans * n_tiles * (max_gap + 1) + 600;

    logic         clk;
    logic         nrst;
    logic         enable;
    logic         step;
    dir_t         dir;
    coord_t       apple_pos;
    logic         diff;
    tile_update_t update;
    logic         dead;
    logic         ate;
    logic [4:0]   length;

    // reference snake, and the tile codes the DUT has reported so far
    coord_t       m_segs [max_len];
    logic [4:0]   m_len;
    logic         m_dead;
    coord_t       m_apple;
    obj_code_t    shown [grid_h][grid_w];
    coord_t       scan_pos;
    coord_t       prev_visit;
    logic [15:0]  lfsr_state = 16'd88;
    int           errors = 0;
    int           diff_total = 0;
    int           scan_diffs = 0;
    int           cycles = 0;

    snake_top #(.max_len(max_len)) DUT (
        .clk(clk), .nrst(nrst), .enable(enable), .step(step), .dir(dir),
        .apple_pos(apple_pos), .diff(diff), .update(update), .dead(dead),
        .ate(ate), .length(length)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic note_failure(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic coord_t next_raster(input coord_t c);
        coord_t n;
        n = c;
        if (c.x == 4'(grid_w - 1)) begin
            n.x = 4'd0;
            n.y = (c.y == 4'(grid_h - 1)) ? 4'd0 : c.y + 4'd1;
        end else begin
            n.x = c.x + 4'd1;
        end
        return n;
    endfunction

    function automatic logic is_edge(input coord_t c);
        return (c.x == 4'd0) || (c.x == 4'd15) || (c.y == 4'd0) || (c.y == 4'd11);
    endfunction

    // priority border, head, body, apple, empty
    function automatic obj_code_t expected_code(input coord_t c);
        if (is_edge(c)) begin
            return tile_border;
        end
        if (c == m_segs[0]) begin
            return tile_head;
        end
        for (int i = 1; i < max_len; i++) begin
            if ((5'(i) < m_len) && (c == m_segs[i])) begin
                return tile_body;
            end
        end
        if (c == m_apple) begin
            return tile_apple;
        end
        return tile_empty;
    endfunction

    function automatic int count_mismatch();
        int n;
        coord_t c;
        n = 0;
        for (int r = 0; r < grid_h; r++) begin
            for (int x = 0; x < grid_w; x++) begin
                c = '{x: 4'(x), y: 4'(r)};
                if (shown[r][x] != expected_code(c)) begin
                    n++;
                end
            end
        end
        return n;
    endfunction

    // returns whether the move lands on the apple
    function automatic logic model_step(input dir_t d);
        coord_t nh;
        logic   hit;
        logic   eat;
        if (m_dead) begin
            return 1'b0;
        end
        nh = m_segs[0];
        case (d)
            dir_right: nh.x = nh.x + 4'd1;
            dir_left:  nh.x = nh.x - 4'd1;
            dir_up:    nh.y = nh.y - 4'd1;
            default:   nh.y = nh.y + 4'd1;
        endcase
        hit = is_edge(nh);
        for (int i = 1; i < max_len; i++) begin
            if ((5'(i) < m_len - 5'd1) && (nh == m_segs[i])) begin
                hit = 1'b1;
            end
        end
        eat = (nh == m_apple);
        for (int i = max_len - 1; i > 0; i--) begin
            m_segs[i] = m_segs[i-1];
        end
        m_segs[0] = nh;
        if (eat && (m_len < 5'(max_len))) begin
            m_len = m_len + 5'd1;
        end
        if (hit) begin
            m_dead = 1'b1;
        end
        return eat;
    endfunction

    // the apple stays off row 5 and column 7, where the snake will travel
    function automatic coord_t pick_apple();
        coord_t c;
        logic   bad;
        bad = 1'b1;
        c = '0;
        while (bad) begin
            c.x = 4'(1 + rand_bits(4) % 14);
            c.y = 4'(1 + rand_bits(4) % 10);
            bad = (c.y == 4'd5) || (c.x == 4'd7);
            for (int i = 0; i < max_len; i++) begin
                if ((5'(i) < m_len) && (c == m_segs[i])) begin
                    bad = 1'b1;
                end
            end
        end
        return c;
    endfunction

    task automatic set_apple(input coord_t c);
        @(posedge clk);
        apple_pos <= c;
        m_apple = c;
    endtask

    task automatic do_step(input dir_t d);
        logic eat;
        @(posedge clk);
        step <= 1'b1;
        dir  <= d;
        @(posedge clk);
        step <= 1'b0;
        eat = model_step(d);
        @(negedge clk);
        assert (ate == eat) else note_failure("ate does not match the move");
        assert (length == m_len) else note_failure("length differs from the model");
        assert (dead == m_dead) else note_failure("dead differs from the model");
    endtask

    // want below zero means only the model decides the number of diffs
    task automatic run_scan(input int gap_bits, input int want);
        int pending;
        int gap;
        pending = count_mismatch();
        scan_diffs = 0;
        for (int n = 0; n < n_tiles; n++) begin
            gap = rand_bits(gap_bits);
            repeat (gap) begin
                @(posedge clk);
                enable <= 1'b0;
            end
            @(posedge clk);
            enable <= 1'b1;
        end
        @(posedge clk);
        enable <= 1'b0;
        repeat (2) @(posedge clk);
        assert (scan_diffs == pending) else note_failure("diff count differs from the model");
        if (want >= 0) begin
            assert (scan_diffs == want) else note_failure("unexpected number of diffs in scan");
        end
        assert (count_mismatch() == 0) else note_failure("reported tiles differ from the model");
    endtask

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            scan_pos   <= '0;
            prev_visit <= '0;
        end else if (enable) begin
            prev_visit <= scan_pos;
            scan_pos   <= next_raster(scan_pos);
        end
    end

    always @(negedge clk) begin
        if (nrst && diff) begin
            diff_total++;
            scan_diffs++;
            assert (update.pos == prev_visit) else note_failure("update is not the visited tile");
            assert (update.code == expected_code(update.pos))
                else note_failure("update code differs from the model");
            assert (update.code != shown[update.pos.y][update.pos.x])
                else note_failure("update repeats the code already shown");
            shown[update.pos.y][update.pos.x] = update.code;
        end
    end

    a_diff_after_enable: assert property (@(posedge clk) disable iff (!nrst)
        diff |-> $past(enable)) else note_failure("diff without an enabled visit");
    a_ate_one_cycle: assert property (@(posedge clk) disable iff (!nrst)
        ate |=> !ate) else note_failure("ate is longer than one cycle");
    a_dead_sticky: assert property (@(posedge clk) disable iff (!nrst)
        dead |=> dead) else note_failure("dead fell before reset");
    a_length_frozen: assert property (@(posedge clk) disable iff (!nrst)
        dead |=> $stable(length)) else note_failure("length changed after death");

    initial begin
        while (cycles < cycle_cap) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_cap);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        m_segs[0] = '{x: 4'd5, y: 4'd5};
        m_segs[1] = '{x: 4'd4, y: 4'd5};
        for (int i = 2; i < max_len; i++) begin
            m_segs[i] = '{x: 4'd3, y: 4'd5};
        end
        m_len  = 5'd3;
        m_dead = 1'b0;
        for (int r = 0; r < grid_h; r++) begin
            for (int x = 0; x < grid_w; x++) begin
                shown[r][x] = tile_empty;
            end
        end
        nrst      = 1'b0;
        enable    = 1'b0;
        step      = 1'b0;
        dir       = dir_right;
        m_apple   = pick_apple();
        apple_pos = m_apple;
        repeat (8) @(posedge clk);
        nrst <= 1'b1;

        // border ring of 52 tiles plus three snake tiles and the apple
        run_scan(0, 56);
        run_scan(0, 0);
        do_step(dir_right);
        run_scan(0, 3);

        // the old apple tile clears and the new one appears
        set_apple('{x: 4'd7, y: 4'd5});
        run_scan(2, 2);
        do_step(dir_right);
        assert (length == 5'd4) else note_failure("length did not grow on the apple");
        run_scan(2, 2);
        assert (shown[5][4] == tile_body) else note_failure("tail did not stay after eating");
        set_apple(pick_apple());
        run_scan(2, 1);

        for (int k = 0; k < 4; k++) begin
            do_step(dir_up);
            run_scan(2, 3);
        end
        do_step(dir_up);
        assert (dead) else note_failure("dead did not rise at the wall");
        run_scan(2, -1);
        do_step(dir_right);
        do_step(dir_right);
        run_scan(2, 0);

        $display("run finished: %0d diffs checked, %0d errors", diff_total, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: snake_top.sv
`timescale 1ns/1ps
`default_nettype none

module snake_top
    import snake_pkg::*;
#(
    parameter int max_len = 16
) (
    input  logic         clk,
    input  logic         nrst,
    input  logic         enable,
    input  logic         step,
    input  dir_t         dir,
    input  coord_t       apple_pos,
    output logic         diff,
    output tile_update_t update,
    output logic         dead,
    output logic         ate,
    output logic [4:0]   length
);

    coord_t [max_len-1:0] segs;
    coord_t               cursor;
    logic                 is_border;
    logic                 is_head;
    logic                 is_body;
    logic                 is_apple;

    snake_body #(
        .max_len(max_len)
    ) u_body (
        .clk      (clk),
        .nrst     (nrst),
        .step     (step),
        .dir      (dir),
        .apple_pos(apple_pos),
        .segs     (segs),
        .length   (length),
        .dead     (dead),
        .ate      (ate)
    );

    cell_lookup #(
        .max_len(max_len)
    ) u_lookup (
        .cursor   (cursor),
        .segs     (segs),
        .length   (length),
        .apple_pos(apple_pos),
        .border   (is_border),
        .head     (is_head),
        .body     (is_body),
        .apple    (is_apple)
    );

    frame_tracker u_tracker (
        .clk   (clk),
        .nrst  (nrst),
        .enable(enable),
        .border(is_border),
        .head  (is_head),
        .body  (is_body),
        .apple (is_apple),
        .cursor(cursor),
        .diff  (diff),
        .update(update)
    );

endmodule

`default_nettype wire

// File: frame_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module frame_tracker
    import snake_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,
    input  logic         enable,
    input  logic         border,
    input  logic         head,
    input  logic         body,
    input  logic         apple,
    output coord_t       cursor,
    output logic         diff,
    output tile_update_t update
);

    localparam logic [3:0] last_x  = 4'(grid_w - 1);
    localparam logic [3:0] last_y  = 4'(grid_h - 1);
    localparam int         n_tiles = grid_w * grid_h;

    // last code reported for every tile, indexed row first
    obj_code_t tile_mem [grid_h][grid_w];

    obj_code_t new_code;
    obj_code_t old_code;
    logic      changed;
    coord_t    next_cursor;
    logic [7:0] visits_since;
    logic      reported;

    always_comb begin
        next_cursor = cursor;
        if (cursor.x == last_x) begin
            next_cursor.x = 4'd0;
            if (cursor.y == last_y) begin
                next_cursor.y = 4'd0;
            end else begin
                next_cursor.y = cursor.y + 4'd1;
            end
        end else begin
            next_cursor.x = cursor.x + 4'd1;
        end
    end

    // border wins over a dead head that ran into the wall
    always_comb begin
        if (border) begin
            new_code = tile_border;
        end else if (head) begin
            new_code = tile_head;
        end else if (body) begin
            new_code = tile_body;
        end else if (apple) begin
            new_code = tile_apple;
        end else begin
            new_code = tile_empty;
        end
    end

    assign old_code = tile_mem[cursor.y][cursor.x];
    assign changed  = enable && (new_code != old_code);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cursor <= '0;
        end else if (enable) begin
            cursor <= next_cursor;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < grid_h; r++) begin
                for (int c = 0; c < grid_w; c++) begin
                    tile_mem[r][c] <= tile_empty;
                end
            end
        end else if (changed) begin
            tile_mem[cursor.y][cursor.x] <= new_code;
        end
    end

    // update keeps the last change so the writer can sample it late
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            diff   <= 1'b0;
            update <= '0;
        end else begin
            diff <= changed;
            if (changed) begin
                update.pos  <= cursor;
                update.code <= new_code;
            end
        end
    end

    // cursor steps taken since the visit behind the last update
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            visits_since <= '0;
            reported     <= 1'b0;
        end else if (changed) begin
            visits_since <= 8'd1;
            reported     <= 1'b1;
        end else if (enable && (visits_since != 8'hff)) begin
            visits_since <= visits_since + 8'd1;
        end
    end

    a_cursor_in_grid: assert property (
        @(posedge clk) disable iff (!nrst)
        (cursor.x <= last_x) && (cursor.y <= last_y)
    );

    // a tile may report again only after the cursor went once around the grid
    a_no_repeat_within_scan: assert property (
        @(posedge clk) disable iff (!nrst)
        changed && reported && (cursor == update.pos) |-> (visits_since >= 8'(n_tiles))
    );

endmodule

`default_nettype wire

// File: cell_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module cell_lookup
    import snake_pkg::*;
#(
    parameter int max_len = 16
) (
    input  coord_t                 cursor,
    input  coord_t [max_len-1:0]   segs,
    input  logic   [4:0]           length,
    input  coord_t                 apple_pos,
    output logic                   border,
    output logic                   head,
    output logic                   body,
    output logic                   apple
);

    logic [max_len-1:0] seg_match;
    logic [max_len-1:0] seg_live;

    // a segment counts only while its index is below the current length
    always_comb begin
        for (int i = 0; i < max_len; i++) begin
            seg_match[i] = (cursor == segs[i]);
            seg_live[i]  = (5'(i) < length);
        end
    end

    assign border = on_border(cursor);
    assign head   = seg_match[0];
    assign apple  = (cursor == apple_pos);

    // segment 0 is the head and is left out of the body match
    always_comb begin
        body = 1'b0;
        for (int i = 1; i < max_len; i++) begin
            if (seg_match[i] && seg_live[i]) begin
                body = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: snake_body.sv
`timescale 1ns/1ps
`default_nettype none

module snake_body
    import snake_pkg::*;
#(
    parameter int max_len = 16
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      step,
    input  dir_t                      dir,
    input  coord_t                    apple_pos,
    output coord_t [max_len-1:0]      segs,
    output logic   [4:0]              length,
    output logic                      dead,
    output logic                      ate
);

    localparam logic [4:0] max_len_w = 5'(max_len);
    localparam logic [4:0] start_len = 5'd3;

    // start position, heading right along row 5
    localparam coord_t start_head = '{x: 4'd5, y: 4'd5};
    localparam coord_t start_mid  = '{x: 4'd4, y: 4'd5};
    localparam coord_t start_tail = '{x: 4'd3, y: 4'd5};

    coord_t next_head;
    logic   hit_self;
    logic   hit_wall;
    logic   eats;
    logic   move;

    assign move = step && !dead;

    always_comb begin
        next_head = segs[0];
        case (dir)
            dir_right: next_head.x = segs[0].x + 4'd1;
            dir_left:  next_head.x = segs[0].x - 4'd1;
            dir_up:    next_head.y = segs[0].y - 4'd1;
            dir_down:  next_head.y = segs[0].y + 4'd1;
            default:   next_head = segs[0];
        endcase
    end

    // the tail leaves its tile on this same step, so it is not counted
    always_comb begin
        hit_self = 1'b0;
        for (int i = 1; i < max_len; i++) begin
            if ((5'(i) < length - 5'd1) && (next_head == segs[i])) begin
                hit_self = 1'b1;
            end
        end
    end

    assign hit_wall = on_border(next_head);
    assign eats     = (next_head == apple_pos);

    // segments past length still shift but are ignored by the lookup
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < max_len; i++) begin
                segs[i] <= start_tail;
            end
            segs[0] <= start_head;
            segs[1] <= start_mid;
        end else if (move) begin
            for (int i = max_len - 1; i > 0; i--) begin
                segs[i] <= segs[i-1];
            end
            segs[0] <= next_head;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            length <= start_len;
            dead   <= 1'b0;
            ate    <= 1'b0;
        end else begin
            ate <= move && eats;
            if (move && eats && (length < max_len_w)) begin
                length <= length + 5'd1;
            end
            if (move && (hit_wall || hit_self)) begin
                dead <= 1'b1;
            end
        end
    end

    a_length_range: assert property (
        @(posedge clk) disable iff (!nrst)
        (length >= start_len) && (length <= max_len_w)
    );

    // once dead the snake is frozen whatever the step input does
    a_frozen_when_dead: assert property (
        @(posedge clk) disable iff (!nrst)
        dead |=> $stable(segs)
    );

endmodule

`default_nettype wire

// File: snake_pkg.sv
`default_nettype none

package snake_pkg;

    // playfield size in tiles, the outer ring of tiles is the border
    localparam int grid_w = 16;
    localparam int grid_h = 12;

    typedef struct packed {
        logic [3:0] x;
        logic [3:0] y;
    } coord_t;

    // tile contents as stored per tile and sent to the display writer
    typedef enum logic [2:0] {
        tile_empty  = 3'd0,
        tile_border = 3'd1,
        tile_head   = 3'd2,
        tile_body   = 3'd3,
        tile_apple  = 3'd4
    } obj_code_t;

    typedef enum logic [1:0] {
        dir_right = 2'd0,
        dir_left  = 2'd1,
        dir_up    = 2'd2,
        dir_down  = 2'd3
    } dir_t;

    // one redraw request for a single tile
    typedef struct packed {
        coord_t    pos;
        obj_code_t code;
    } tile_update_t;

    // both the death check and the tile classification need the same edge test
    function automatic logic on_border(coord_t c);
        logic edge_x;
        logic edge_y;
        edge_x = (c.x == 4'd0) || (c.x == 4'(grid_w - 1));
        edge_y = (c.y == 4'd0) || (c.y == 4'(grid_h - 1));
        return edge_x || edge_y;
    endfunction

endpackage

`default_nettype wire
